// File: logic/pak_pkg.sv
package pak_pkg;

	// Packet field widths
	parameter int ADDR_W = 6;
	parameter int DATA_W = 4;
	parameter int RED_W = 4;

	// Serial link width and packet length in nibbles
	parameter int NIB_W = 4;
	parameter int PAK_NIBS = (2 * ADDR_W + DATA_W + RED_W) / NIB_W;

	// Packet layout, src in the top bits
	typedef struct packed {
		logic [ADDR_W-1:0] src;
		logic [ADDR_W-1:0] dst;
		logic [DATA_W-1:0] dat;
		logic [RED_W-1:0] red;
	} pak_t;

	// Debug cases selectable on the LEDs
	typedef enum logic [3:0] {
		DBG_PAK_CNT = 4'd0,
		DBG_ERR_CNT = 4'd1,
		DBG_LAST_DST = 4'd2,
		DBG_LAST_DAT = 4'd3
	} dbg_case_e;

	// XOR of the four nibbles covering src, dst and dat
	function automatic logic [RED_W-1:0] pak_red(
		input logic [ADDR_W-1:0] src,
		input logic [ADDR_W-1:0] dst,
		input logic [DATA_W-1:0] dat
	);
		logic [2*ADDR_W+DATA_W-1:0] word;
		word = {src, dst, dat};
		return word[15:12] ^ word[11:8] ^ word[7:4] ^ word[3:0];
	endfunction

endpackage

// File: logic/pak_link_if.sv
`timescale 1ns/1ps

// Parallel packet link between blocks
// Fields are only meaningful while valid is high, no back-pressure
interface pak_link_if;

	// One-cycle packet strobe
	logic valid;

	// Packet fields
	pak_pkg::pak_t pak;

	// Producer side
	modport src (
		output valid,
		output pak
	);

	// Consumer side
	modport dst (
		input valid,
		input pak
	);

endinterface

// File: logic/pak_source.sv
`timescale 1ns/1ps

module pak_source #(
	parameter int SRC_ADDR = 23,
	parameter int MIN_ADDR = 1,
	parameter int MAX_ADDR = 14,
	parameter int PERIOD = 8
) (
	input logic i_clk,
	input logic i_arst_n,
	input logic i_enable,
	pak_link_if.src o_link
);

	localparam int AW = pak_pkg::ADDR_W;
	localparam int DW = pak_pkg::DATA_W;
	localparam int TICK_W = $clog2(PERIOD + 1);

	logic [TICK_W-1:0] tick;
	logic fire;
	logic [AW-1:0] dst;
	logic [DW-1:0] dat;
	pak_pkg::pak_t pak_next;

	// Strobe on the last tick of each period
	assign fire = i_enable && (tick == TICK_W'(PERIOD - 1));

	// Tick counter, held at zero while disabled
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			tick <= '0;
		end else if (!i_enable || fire) begin
			tick <= '0;
		end else begin
			tick <= tick + 1'b1;
		end
	end

	// Walking destination and counting data
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			dst <= AW'(MIN_ADDR);
			dat <= '0;
		end else if (fire) begin
			if (dst == AW'(MAX_ADDR)) begin
				dst <= AW'(MIN_ADDR);
			end else begin
				dst <= dst + 1'b1;
			end
			// Wraps naturally at 16
			dat <= dat + 1'b1;
		end
	end

	always_comb begin
		pak_next.src = AW'(SRC_ADDR);
		pak_next.dst = dst;
		pak_next.dat = dat;
		pak_next.red = pak_pkg::pak_red(AW'(SRC_ADDR), dst, dat);
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_link.valid <= 1'b0;
		end else begin
			o_link.valid <= fire;
		end
	end

	// Packet payload
	always_ff @(posedge i_clk) begin
		if (fire) begin
			o_link.pak <= pak_next;
		end
	end

endmodule

// File: logic/pak_serial_tx.sv
`timescale 1ns/1ps

module pak_serial_tx (
	input logic i_clk,
	input logic i_arst_n,
	pak_link_if.dst i_link,
	input logic i_corrupt,
	output logic o_ser_valid,
	output logic [pak_pkg::NIB_W-1:0] o_ser_nib
);

	localparam int NW = pak_pkg::NIB_W;
	localparam int PAK_W = $bits(pak_pkg::pak_t);
	localparam int CNT_W = $clog2(pak_pkg::PAK_NIBS);

	logic [PAK_W-1:0] shreg;
	logic [CNT_W-1:0] left;
	logic busy;
	logic corrupt_pend;
	logic flip;
	pak_pkg::pak_t pak_load;

	// A strobe in the same cycle as a packet still counts
	assign flip = corrupt_pend | i_corrupt;

	// Flip data bit 0, red stays as the source built it
	always_comb begin
		pak_load = i_link.pak;
		pak_load.dat[0] = i_link.pak.dat[0] ^ flip;
	end

	// Sticky corrupt request, consumed by the next packet
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			corrupt_pend <= 1'b0;
		end else if (i_link.valid) begin
			corrupt_pend <= 1'b0;
		end else if (i_corrupt) begin
			corrupt_pend <= 1'b1;
		end
	end

	// Nibble sequencing control
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy <= 1'b0;
			left <= '0;
		end else if (i_link.valid) begin
			busy <= 1'b1;
			left <= CNT_W'(pak_pkg::PAK_NIBS - 1);
		end else if (busy) begin
			if (left == '0) begin
				busy <= 1'b0;
			end else begin
				left <= left - 1'b1;
			end
		end
	end

	// Shift out MSB nibble first
	always_ff @(posedge i_clk) begin
		if (i_link.valid) begin
			shreg <= pak_load;
		end else if (busy) begin
			shreg <= {shreg[PAK_W-NW-1:0], {NW{1'b0}}};
		end
	end

	assign o_ser_valid = busy;
	assign o_ser_nib = shreg[PAK_W-1 -: NW];

endmodule

// File: logic/pak_serial_rx.sv
`timescale 1ns/1ps

module pak_serial_rx (
	input logic i_clk,
	input logic i_arst_n,
	input logic i_ser_valid,
	input logic [pak_pkg::NIB_W-1:0] i_ser_nib,
	pak_link_if.src o_link,
	output logic o_red_err
);

	localparam int NW = pak_pkg::NIB_W;
	localparam int HOLD_W = (pak_pkg::PAK_NIBS - 1) * NW;
	localparam int CNT_W = $clog2(pak_pkg::PAK_NIBS);

	// First four nibbles of the packet in flight
	logic [HOLD_W-1:0] shreg;
	logic [CNT_W-1:0] cnt;
	logic last_nib;
	pak_pkg::pak_t pak_asm;
	logic red_bad;

	assign last_nib = i_ser_valid && (cnt == CNT_W'(pak_pkg::PAK_NIBS - 1));

	// Complete packet once the fifth nibble is on the link
	assign pak_asm = {shreg, i_ser_nib};

	assign red_bad = pak_asm.red !=
		pak_pkg::pak_red(pak_asm.src, pak_asm.dst, pak_asm.dat);

	// Nibble counter
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			cnt <= '0;
		end else if (last_nib) begin
			cnt <= '0;
		end else if (i_ser_valid) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_ser_valid) begin
			shreg <= {shreg[HOLD_W-NW-1:0], i_ser_nib};
		end
	end

	// Receive strobe and check result
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_link.valid <= 1'b0;
			o_red_err <= 1'b0;
		end else begin
			o_link.valid <= last_nib;
			o_red_err <= last_nib && red_bad;
		end
	end

	// Rebuilt packet payload
	always_ff @(posedge i_clk) begin
		if (last_nib) begin
			o_link.pak <= pak_asm;
		end
	end

endmodule

// File: logic/pak_dbg_regs.sv
`timescale 1ns/1ps

module pak_dbg_regs (
	input logic i_clk,
	input logic i_arst_n,
	pak_link_if.dst i_link,
	input logic i_red_err,
	input logic [3:0] i_dbg_case,
	input logic i_dbg_load,
	output logic [3:0] o_leds
);

	logic [3:0] pak_cnt;
	logic [3:0] err_cnt;
	logic [3:0] last_dst;
	logic [pak_pkg::DATA_W-1:0] last_dat;
	pak_pkg::dbg_case_e case_sel;
	logic [3:0] led_next;

	// Packet and error counters, wrap at 16
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			pak_cnt <= '0;
			err_cnt <= '0;
		end else if (i_link.valid) begin
			pak_cnt <= pak_cnt + 1'b1;
			if (i_red_err) begin
				err_cnt <= err_cnt + 1'b1;
			end
		end
	end

	// Last packet seen
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			last_dst <= '0;
			last_dat <= '0;
		end else if (i_link.valid) begin
			last_dst <= i_link.pak.dst[3:0];
			last_dat <= i_link.pak.dat;
		end
	end

	// Selected debug case
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			case_sel <= pak_pkg::DBG_PAK_CNT;
		end else if (i_dbg_load) begin
			case_sel <= pak_pkg::dbg_case_e'(i_dbg_case);
		end
	end

	// LED select, unknown cases show zero
	always_comb begin
		case (case_sel)
			pak_pkg::DBG_PAK_CNT: begin
				led_next = pak_cnt;
			end
			pak_pkg::DBG_ERR_CNT: begin
				led_next = err_cnt;
			end
			pak_pkg::DBG_LAST_DST: begin
				led_next = last_dst;
			end
			pak_pkg::DBG_LAST_DAT: begin
				led_next = last_dat;
			end
			default: begin
				led_next = 4'd0;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_leds <= '0;
		end else begin
			o_leds <= led_next;
		end
	end

endmodule

// File: logic/pak_test_top.sv
`timescale 1ns/1ps

module pak_test_top #(
	parameter int SRC_ADDR = 23,
	parameter int MIN_ADDR = 1,
	parameter int MAX_ADDR = 14,
	parameter int PERIOD = 8
) (
	input logic i_clk,
	input logic i_arst_n,
	input logic i_enable,
	input logic i_corrupt,
	input logic [3:0] i_dbg_case,
	input logic i_dbg_load,
	output logic [3:0] o_leds,
	output logic o_pak_valid,
	output logic [pak_pkg::ADDR_W-1:0] o_pak_src,
	output logic [pak_pkg::ADDR_W-1:0] o_pak_dst,
	output logic [pak_pkg::DATA_W-1:0] o_pak_dat,
	output logic o_pak_err
);

	// Generated and received packet links
	pak_link_if link_gen ();
	pak_link_if link_rcv ();

	// Nibble link between transmitter and receiver
	logic ser_valid;
	logic [pak_pkg::NIB_W-1:0] ser_nib;
	logic red_err;

	pak_source #(
		.SRC_ADDR (SRC_ADDR),
		.MIN_ADDR (MIN_ADDR),
		.MAX_ADDR (MAX_ADDR),
		.PERIOD (PERIOD)
	) pak_source_inst (
		.i_clk (i_clk),
		.i_arst_n (i_arst_n),
		.i_enable (i_enable),
		.o_link (link_gen.src)
	);

	pak_serial_tx pak_serial_tx_inst (
		.i_clk (i_clk),
		.i_arst_n (i_arst_n),
		.i_link (link_gen.dst),
		.i_corrupt (i_corrupt),
		.o_ser_valid (ser_valid),
		.o_ser_nib (ser_nib)
	);

	pak_serial_rx pak_serial_rx_inst (
		.i_clk (i_clk),
		.i_arst_n (i_arst_n),
		.i_ser_valid (ser_valid),
		.i_ser_nib (ser_nib),
		.o_link (link_rcv.src),
		.o_red_err (red_err)
	);

	pak_dbg_regs pak_dbg_regs_inst (
		.i_clk (i_clk),
		.i_arst_n (i_arst_n),
		.i_link (link_rcv.dst),
		.i_red_err (red_err),
		.i_dbg_case (i_dbg_case),
		.i_dbg_load (i_dbg_load),
		.o_leds (o_leds)
	);

	// Received packet straight out
	assign o_pak_valid = link_rcv.valid;
	assign o_pak_src = link_rcv.pak.src;
	assign o_pak_dst = link_rcv.pak.dst;
	assign o_pak_dat = link_rcv.pak.dat;
	assign o_pak_err = red_err;

endmodule

// File: verification/pak_test_tb.sv
`timescale 1ns/1ps

module pak_test_tb;

	localparam int SRC_ADDR = 23;
	localparam int MIN_ADDR = 1;
	localparam int MAX_ADDR = 14;
	localparam int PERIOD = 8;
	localparam int PLANNED = 40;

	logic clk;
	logic arst_n;
	logic enable;
	logic corrupt;
	logic [3:0] dbg_case;
	logic dbg_load;
	logic [3:0] o_leds;
	logic o_pak_valid;
	logic [5:0] o_pak_src;
	logic [5:0] o_pak_dst;
	logic [3:0] o_pak_dat;
	logic o_pak_err;

	// Reference model state
	logic [5:0] exp_dst;
	logic [3:0] exp_dat;
	logic [3:0] pak_cnt;
	logic [3:0] err_cnt;
	logic [3:0] last_dst;
	logic [3:0] last_dat;
	logic corrupt_armed;
	int cyc;
	int last_rx_cyc;
	int rx_count;
	int late_count;
	integer seed;
	logic [31:0] pick;

	pak_test_top #(
		.SRC_ADDR (SRC_ADDR),
		.MIN_ADDR (MIN_ADDR),
		.MAX_ADDR (MAX_ADDR),
		.PERIOD (PERIOD)
	) pak_test_top_inst (
		.i_clk (clk),
		.i_arst_n (arst_n),
		.i_enable (enable),
		.i_corrupt (corrupt),
		.i_dbg_case (dbg_case),
		.i_dbg_load (dbg_load),
		.o_leds (o_leds),
		.o_pak_valid (o_pak_valid),
		.o_pak_src (o_pak_src),
		.o_pak_dst (o_pak_dst),
		.o_pak_dat (o_pak_dat),
		.o_pak_err (o_pak_err)
	);

	initial begin
		clk = 1'b0;
	end

	always #20 clk = ~clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	function automatic string mismatch_text(input string name, input int exp_val,
		input int act_val);
		return $sformatf("mismatch at %0t: %s expected %0d, got %0d", $time, name,
			exp_val, act_val);
	endfunction

	// An error flag only ever comes with a received packet
	assert property (@(posedge clk) o_pak_err |-> o_pak_valid)
		else report_failure(mismatch_text("o_pak_err", 0, $sampled(o_pak_err)));

	task automatic check_idle();
		assert (o_leds == 4'd0) else report_failure(mismatch_text("o_leds", 0, o_leds));
		assert (!o_pak_valid) else report_failure(mismatch_text("o_pak_valid", 0, o_pak_valid));
		assert (!o_pak_err) else report_failure(mismatch_text("o_pak_err", 0, o_pak_err));
	endtask

	// Compare one received packet with the model, then advance the model
	task automatic check_packet();
		logic [3:0] dat_exp;
		dat_exp = exp_dat ^ {3'b000, corrupt_armed};
		if (enable && rx_count > 0) begin
			assert (cyc - last_rx_cyc == PERIOD)
				else report_failure(mismatch_text("o_pak_valid spacing", PERIOD,
					cyc - last_rx_cyc));
		end
		if (!enable) begin
			late_count = late_count + 1;
			assert (late_count <= 1)
				else report_failure("more than one packet arrived after disable");
		end
		assert (o_pak_src == SRC_ADDR)
			else report_failure(mismatch_text("o_pak_src", SRC_ADDR, o_pak_src));
		assert (o_pak_dst == exp_dst)
			else report_failure(mismatch_text("o_pak_dst", exp_dst, o_pak_dst));
		assert (o_pak_dat == dat_exp)
			else report_failure(mismatch_text("o_pak_dat", dat_exp, o_pak_dat));
		assert (o_pak_err == corrupt_armed)
			else report_failure(mismatch_text("o_pak_err", corrupt_armed, o_pak_err));
		pak_cnt = pak_cnt + 1'b1;
		if (corrupt_armed) begin
			err_cnt = err_cnt + 1'b1;
		end
		last_dst = exp_dst[3:0];
		last_dat = dat_exp;
		exp_dst = (exp_dst == MAX_ADDR) ? 6'(MIN_ADDR) : exp_dst + 1'b1;
		exp_dat = exp_dat + 1'b1;
		corrupt_armed = 1'b0;
		last_rx_cyc = cyc;
		rx_count = rx_count + 1;
	endtask

	// Mid-cycle receive monitor
	always @(negedge clk) begin
		if (arst_n) begin
			cyc = cyc + 1;
			if (o_pak_valid) begin
				check_packet();
			end
		end
	end

	function automatic logic [3:0] leds_expected(input logic [3:0] sel);
		case (sel)
			4'd0: return pak_cnt;
			4'd1: return err_cnt;
			4'd2: return last_dst;
			4'd3: return last_dat;
			default: return 4'd0;
		endcase
	endfunction

	task automatic wait_rx();
		@(negedge clk);
		while (!o_pak_valid) begin
			@(negedge clk);
		end
	endtask

	// Corrupts the packet the source sends next
	task automatic inject_corrupt();
		@(posedge clk);
		#2;
		corrupt = 1'b1;
		corrupt_armed = 1'b1;
		@(posedge clk);
		#2;
		corrupt = 1'b0;
	endtask

	task automatic load_and_check_leds(input logic [3:0] sel);
		@(posedge clk);
		#2;
		dbg_case = sel;
		dbg_load = 1'b1;
		@(posedge clk);
		#2;
		dbg_load = 1'b0;
		// Case register loaded, LEDs follow one edge later
		@(posedge clk);
		@(negedge clk);
		assert (o_leds == leds_expected(sel))
			else report_failure(mismatch_text($sformatf("o_leds (case %0d)", sel),
				leds_expected(sel), o_leds));
	endtask

	initial begin
		#((PLANNED + 20) * PERIOD * 40);
		report_failure("timeout: the expected packets never all arrived");
	end

	initial begin
		seed = 90;
		arst_n = 1'b0;
		enable = 1'b0;
		corrupt = 1'b0;
		dbg_case = 4'd0;
		dbg_load = 1'b0;
		exp_dst = 6'(MIN_ADDR);
		exp_dat = 4'd0;
		pak_cnt = 4'd0;
		err_cnt = 4'd0;
		last_dst = 4'd0;
		last_dat = 4'd0;
		corrupt_armed = 1'b0;
		cyc = 0;
		last_rx_cyc = 0;
		rx_count = 0;
		late_count = 0;
		repeat (10) begin
			@(negedge clk);
			check_idle();
		end
		@(posedge clk);
		#2;
		arst_n = 1'b1;
		repeat (2) begin
			@(negedge clk);
			check_idle();
		end
		@(posedge clk);
		#2;
		enable = 1'b1;
		for (int i = 0; i < PLANNED; i++) begin
			wait_rx();
			pick = $random(seed);
			// Fixed opening covers every case and one clean packet after an error
			if (i < 5) begin
				load_and_check_leds((i == 4) ? 4'd12 : 4'(i));
			end else if (i == 5) begin
				inject_corrupt();
			end else if (i == 6) begin
				load_and_check_leds(4'd1);
			end else if (i == 7) begin
				load_and_check_leds(4'd3);
			end else if (pick[1:0] == 2'd0) begin
				inject_corrupt();
			end else if (pick[1:0] == 2'd1) begin
				load_and_check_leds({1'b0, pick[4:2]});
			end
		end
		@(posedge clk);
		#2;
		enable = 1'b0;
		repeat (3 * PERIOD) begin
			@(negedge clk);
		end
		// Packet count must include any packet that landed after disable
		load_and_check_leds(4'd0);
		$display("All tests passed!");
		$finish;
	end

endmodule

// File: verilog.f
logic/pak_pkg.sv
logic/pak_link_if.sv
logic/pak_source.sv
logic/pak_serial_tx.sv
logic/pak_serial_rx.sv
logic/pak_dbg_regs.sv
logic/pak_test_top.sv
verification/pak_test_tb.sv
